// ==== ddr3_mon.f ====
hw/ddr3_mon_pkg.sv
hw/cmd_decode.sv
hw/bank_tracker.sv
hw/cmd_counters.sv
hw/mon_ctrl.sv
hw/ddr3_mon_top.sv
tests/ddr3_mon_sva.sv
tests/ddr3_mon_tb.sv

// ==== hw/bank_tracker.sv ====
module bank_tracker import ddr3_mon_pkg::*; (
	input  logic                 ck,
	input  logic                 rst,
	input  ddr_cmd_t             cmd,
	input  logic                 cmd_valid,
	output logic [NUM_BANKS-1:0] open_mask,
	output access_t              acc,
	output logic                 acc_valid,
	output viol_e                viol,
	output logic                 viol_valid
);

	logic [NUM_BANKS-1:0] bank_open;
	logic [ROW_W-1:0]     bank_row [NUM_BANKS];
	logic                 is_act;
	logic                 is_pre;
	logic                 is_access;
	logic                 hit_open;
	viol_e                viol_d;

	assign is_act    = cmd_valid && (cmd.op == OP_ACT);
	assign is_pre    = cmd_valid && (cmd.op == OP_PRE);
	assign is_access = cmd_valid && ((cmd.op == OP_RD) || (cmd.op == OP_WR));
	assign hit_open  = bank_open[cmd.ba];

	assign open_mask = bank_open;

	// ----------------------------------------
	// protocol checks
	// ----------------------------------------
	always_comb begin
		viol_d = VIOL_NONE;
		if (is_act && hit_open) begin
			viol_d = VIOL_ACT_OPEN;
		end else if (is_access && !hit_open) begin
			viol_d = VIOL_ACCESS_CLOSED;
		end
	end

	// ----------------------------------------
	// per-bank open state
	// ----------------------------------------
	always_ff @(posedge ck) begin
		if (rst) begin
			bank_open <= '0;
		end else if (is_act) begin
			bank_open[cmd.ba] <= 1'b1;
		end else if (is_pre) begin
			// a10 selects precharge-all
			if (cmd.a[10]) begin
				bank_open <= '0;
			end else begin
				bank_open[cmd.ba] <= 1'b0;
			end
		end else if (is_access && cmd.a[10]) begin
			// auto-precharge closes after the access
			bank_open[cmd.ba] <= 1'b0;
		end
	end

	// row latched on ACT, also on ACT to an open bank
	always_ff @(posedge ck) begin
		if (rst) begin
			for (int i = 0; i < NUM_BANKS; i++) begin
				bank_row[i] <= '0;
			end
		end else if (is_act) begin
			bank_row[cmd.ba] <= cmd.a;
		end
	end

	// ----------------------------------------
	// access record and violation pulse
	// ----------------------------------------
	always_ff @(posedge ck) begin
		if (rst) begin
			acc_valid  <= 1'b0;
			viol_valid <= 1'b0;
			viol       <= VIOL_NONE;
		end else begin
			acc_valid  <= is_access;
			viol_valid <= (viol_d != VIOL_NONE);
			viol       <= viol_d;
		end
	end

	// closed bank still reports its stale row
	always_ff @(posedge ck) begin
		if (is_access) begin
			acc.is_wr <= (cmd.op == OP_WR);
			acc.ba    <= cmd.ba;
			acc.row   <= bank_row[cmd.ba];
			acc.col   <= cmd.a[COL_W-1:0];
		end
	end

endmodule

// ==== hw/cmd_counters.sv ====
module cmd_counters import ddr3_mon_pkg::*; #(
	parameter int CNT_W = 32
) (
	input  logic                            ck,
	input  logic                            rst,
	input  ddr_cmd_t                        cmd,
	input  logic                            cmd_valid,
	input  logic                            count_en,
	input  logic                            count_clr,
	output logic [NUM_CNT-1:0][CNT_W-1:0]   cnt
);

	logic [NUM_CNT-1:0] hit;

	// one-hot select of the counter slot
	always_comb begin
		hit = '0;
		if (cmd_valid && count_en) begin
			case (cmd.op)
				OP_ACT:  hit[CNT_ACT] = 1'b1;
				OP_PRE:  hit[CNT_PRE] = 1'b1;
				OP_RD:   hit[CNT_RD]  = 1'b1;
				OP_WR:   hit[CNT_WR]  = 1'b1;
				OP_REF:  hit[CNT_REF] = 1'b1;
				OP_MRS:  hit[CNT_MRS] = 1'b1;
				OP_ZQ:   hit[CNT_ZQ]  = 1'b1;
				default: hit = '0;
			endcase
		end
	end

	// ----------------------------------------
	// saturating counters
	// ----------------------------------------
	always_ff @(posedge ck) begin
		if (rst) begin
			cnt <= '0;
		end else begin
			for (int i = 0; i < NUM_CNT; i++) begin
				// clear wins over a same-cycle increment
				if (count_clr) begin
					cnt[i] <= '0;
				end else if (hit[i] && (cnt[i] != {CNT_W{1'b1}})) begin
					cnt[i] <= cnt[i] + 1'b1;
				end
			end
		end
	end

endmodule

// ==== hw/cmd_decode.sv ====
module cmd_decode import ddr3_mon_pkg::*; (
	input  logic             ck,
	input  logic             rst,
	input  logic             cs_n,
	input  logic             ras_n,
	input  logic             cas_n,
	input  logic             we_n,
	input  logic [BA_W-1:0]  ba,
	input  logic [ROW_W-1:0] a,
	output ddr_cmd_t         cmd,
	output logic             cmd_valid
);

	cmd_op_e op_d;

	// DDR3 truth table, deselect reads as NOP
	always_comb begin
		if (cs_n) begin
			op_d = OP_NOP;
		end else begin
			case ({ras_n, cas_n, we_n})
				3'b000:  op_d = OP_MRS;
				3'b001:  op_d = OP_REF;
				3'b010:  op_d = OP_PRE;
				3'b011:  op_d = OP_ACT;
				3'b100:  op_d = OP_WR;
				3'b101:  op_d = OP_RD;
				3'b110:  op_d = OP_ZQ;
				default: op_d = OP_NOP;
			endcase
		end
	end

	always_ff @(posedge ck) begin
		if (rst) begin
			cmd.op    <= OP_NOP;
			cmd_valid <= 1'b0;
		end else begin
			cmd.op    <= op_d;
			cmd_valid <= (op_d != OP_NOP);
		end
	end

	// address and bank just ride along
	always_ff @(posedge ck) begin
		cmd.ba <= ba;
		cmd.a  <= a;
	end

endmodule

// ==== hw/ddr3_mon_pkg.sv ====
package ddr3_mon_pkg;

	// ----------------------------------------
	// bus geometry
	// ----------------------------------------
	localparam int ROW_W     = 13;
	localparam int COL_W     = 10;
	localparam int NUM_BANKS = 8;
	localparam int BA_W      = $clog2(NUM_BANKS);

	// encoding follows {ras_n, cas_n, we_n}
	typedef enum logic [2:0] {
		OP_MRS = 3'b000,
		OP_REF = 3'b001,
		OP_PRE = 3'b010,
		OP_ACT = 3'b011,
		OP_WR  = 3'b100,
		OP_RD  = 3'b101,
		OP_ZQ  = 3'b110,
		OP_NOP = 3'b111
	} cmd_op_e;

	typedef enum logic [1:0] {
		VIOL_NONE          = 2'd0,
		VIOL_ACT_OPEN      = 2'd1,
		VIOL_ACCESS_CLOSED = 2'd2
	} viol_e;

	typedef struct packed {
		cmd_op_e          op;
		logic [BA_W-1:0]  ba;
		logic [ROW_W-1:0] a;
	} ddr_cmd_t;

	typedef struct packed {
		logic             is_wr;
		logic [BA_W-1:0]  ba;
		logic [ROW_W-1:0] row;
		logic [COL_W-1:0] col;
	} access_t;

	// ----------------------------------------
	// register map
	// ----------------------------------------
	localparam logic [7:0] REG_CTRL     = 8'h00;
	localparam logic [7:0] REG_STATUS   = 8'h04;
	localparam logic [7:0] REG_OPEN     = 8'h08;
	localparam logic [7:0] REG_LAST     = 8'h0C;
	localparam logic [7:0] REG_CNT_BASE = 8'h10;

	// counter slots, one word each from REG_CNT_BASE
	localparam int NUM_CNT = 7;
	localparam int CNT_ACT = 0;
	localparam int CNT_PRE = 1;
	localparam int CNT_RD  = 2;
	localparam int CNT_WR  = 3;
	localparam int CNT_REF = 4;
	localparam int CNT_MRS = 5;
	localparam int CNT_ZQ  = 6;

endpackage

// ==== hw/ddr3_mon_top.sv ====
module ddr3_mon_top import ddr3_mon_pkg::*; #(
	parameter int CNT_W = 32
) (
	input  logic             ck,
	input  logic             rst,
	// command pins
	input  logic             cs_n,
	input  logic             ras_n,
	input  logic             cas_n,
	input  logic             we_n,
	input  logic [BA_W-1:0]  ba,
	input  logic [ROW_W-1:0] a,
	// APB slave
	input  logic [7:0]       paddr,
	input  logic             psel,
	input  logic             penable,
	input  logic             pwrite,
	input  logic [31:0]      pwdata,
	output logic [31:0]      prdata,
	output logic             pready,
	output logic             irq
);

	ddr_cmd_t                      cmd;
	logic                          cmd_valid;
	logic [NUM_BANKS-1:0]          open_mask;
	access_t                       acc;
	logic                          acc_valid;
	viol_e                         viol;
	logic                          viol_valid;
	logic [NUM_CNT-1:0][CNT_W-1:0] cnt;
	logic                          count_en;
	logic                          count_clr;

	cmd_decode u_decode (
		.ck, .rst,
		.cs_n, .ras_n, .cas_n, .we_n, .ba, .a,
		.cmd, .cmd_valid
	);

	bank_tracker u_tracker (
		.ck, .rst,
		.cmd, .cmd_valid,
		.open_mask, .acc, .acc_valid, .viol, .viol_valid
	);

	cmd_counters #(.CNT_W(CNT_W)) u_counters (
		.ck, .rst,
		.cmd, .cmd_valid,
		.count_en, .count_clr,
		.cnt
	);

	mon_ctrl #(.CNT_W(CNT_W)) u_ctrl (
		.ck, .rst,
		.paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready,
		.open_mask, .acc, .acc_valid, .viol, .viol_valid, .cnt,
		.count_en, .count_clr, .irq
	);

endmodule

// ==== hw/mon_ctrl.sv ====
module mon_ctrl import ddr3_mon_pkg::*; #(
	parameter int CNT_W = 32
) (
	input  logic                            ck,
	input  logic                            rst,
	// APB slave
	input  logic [7:0]                      paddr,
	input  logic                            psel,
	input  logic                            penable,
	input  logic                            pwrite,
	input  logic [31:0]                     pwdata,
	output logic [31:0]                     prdata,
	output logic                            pready,
	// monitor results
	input  logic [NUM_BANKS-1:0]            open_mask,
	input  access_t                         acc,
	input  logic                            acc_valid,
	input  viol_e                           viol,
	input  logic                            viol_valid,
	input  logic [NUM_CNT-1:0][CNT_W-1:0]   cnt,
	output logic                            count_en,
	output logic                            count_clr,
	output logic                            irq
);

	logic       wr_en;
	logic       ctrl_en;
	logic       clr_q;
	logic [1:0] status;
	logic [1:0] status_set;
	logic [1:0] status_clr;
	access_t    last_acc;
	logic [7:0] cnt_off;
	logic [2:0] cnt_idx;
	logic       cnt_hit;

	// no wait states
	assign pready = 1'b1;

	assign wr_en = psel && penable && pwrite;

	// ----------------------------------------
	// CTRL register
	// ----------------------------------------
	always_ff @(posedge ck) begin
		if (rst) begin
			ctrl_en <= 1'b1;
			clr_q   <= 1'b0;
		end else begin
			clr_q <= 1'b0;
			if (wr_en && (paddr == REG_CTRL)) begin
				ctrl_en <= pwdata[0];
				clr_q   <= pwdata[1];
			end
		end
	end

	assign count_en  = ctrl_en;
	assign count_clr = clr_q;

	// ----------------------------------------
	// sticky status, write 1 to clear
	// ----------------------------------------
	assign status_set[0] = ctrl_en && viol_valid && (viol == VIOL_ACT_OPEN);
	assign status_set[1] = ctrl_en && viol_valid && (viol == VIOL_ACCESS_CLOSED);
	assign status_clr    = (wr_en && (paddr == REG_STATUS)) ? pwdata[1:0] : 2'b00;

	always_ff @(posedge ck) begin
		if (rst) begin
			status <= 2'b00;
		end else begin
			// a new event beats a same-cycle clear
			status <= status_set | (status & ~status_clr);
		end
	end

	assign irq = |status;

	// last access seen while enabled
	always_ff @(posedge ck) begin
		if (rst) begin
			last_acc <= '0;
		end else if (acc_valid && ctrl_en) begin
			last_acc <= acc;
		end
	end

	// ----------------------------------------
	// read mux
	// ----------------------------------------
	assign cnt_off = paddr - REG_CNT_BASE;
	assign cnt_idx = cnt_off[4:2];
	assign cnt_hit = (cnt_off < 8'(NUM_CNT * 4)) && (cnt_off[1:0] == 2'b00);

	always_comb begin
		prdata = '0;
		case (paddr)
			REG_CTRL:   prdata[0] = ctrl_en;
			REG_STATUS: prdata[1:0] = status;
			REG_OPEN:   prdata[NUM_BANKS-1:0] = open_mask;
			REG_LAST:   prdata[$bits(access_t)-1:0] = last_acc;
			default: begin
				// counter window, anything else reads 0
				if (cnt_hit) begin
					prdata[CNT_W-1:0] = cnt[cnt_idx];
				end
			end
		endcase
	end

endmodule

// ==== tests/ddr3_mon_sva.sv ====
module ddr3_mon_sva import ddr3_mon_pkg::*; (
	input logic       ck,
	input logic       rst,
	input logic       pready,
	input logic       irq,
	input logic [1:0] status,
	input ddr_cmd_t   cmd,
	input logic       cmd_valid,
	input logic       acc_valid,
	input logic       viol_valid
);

	// APB slave never stalls
	a_pready_high: assert property (@(posedge ck) pready)
		else $error("pready went low");

	a_irq_status: assert property (@(posedge ck) disable iff (rst) irq == |status)
		else $error("irq does not follow the status bits");

	a_viol_after_rst: assert property (@(posedge ck) $past(rst) |-> !viol_valid)
		else $error("viol_valid high right after reset");

	// access record comes only from a RD or WR one cycle earlier
	a_acc_from_rw: assert property (@(posedge ck) disable iff (rst)
		acc_valid |-> $past(cmd_valid && (cmd.op == OP_RD || cmd.op == OP_WR)))
		else $error("acc_valid without a RD or WR");

endmodule

bind ddr3_mon_top ddr3_mon_sva sva0 (
	.ck, .rst, .pready, .irq,
	.status(u_ctrl.status),
	.cmd, .cmd_valid, .acc_valid, .viol_valid
);

// ==== tests/ddr3_mon_tb.sv ====
module ddr3_mon_tb import ddr3_mon_pkg::*; ();

	localparam int    CLK_PERIOD    = 8;
	localparam int    CYCLES_PER_OP = 10;
	localparam int    MARGIN        = 400;
	localparam string VEC_FILE      = "tests/ddr3_mon_vectors.txt";

	logic             ck;
	logic             rst;
	logic             cs_n;
	logic             ras_n;
	logic             cas_n;
	logic             we_n;
	logic [BA_W-1:0]  ba;
	logic [ROW_W-1:0] a;
	logic [7:0]       paddr;
	logic             psel;
	logic             penable;
	logic             pwrite;
	logic [31:0]      pwdata;
	logic [31:0]      prdata;
	logic             pready;
	logic             irq;

	string ops[$];

	ddr3_mon_top #(.CNT_W(32)) dut0 (.*);

	always #(CLK_PERIOD / 2) ck = ~ck;

	task automatic abort_run(input string reason);
		$display("Errors found");
		$fatal(1, "%s", reason);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("** Error %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
			abort_run({"register read mismatch in ", name});
		end
	endtask

	// ----------------------------------------
	// bus drivers
	// ----------------------------------------
	task automatic drive_cmd(input logic cs, input logic ras, input logic cas, input logic we,
			input logic [BA_W-1:0] bank, input logic [ROW_W-1:0] addr);
		@(negedge ck);
		{cs_n, ras_n, cas_n, we_n} = {cs, ras, cas, we};
		ba = bank;
		a  = addr;
		// deselect for the following cycle
		@(negedge ck);
		{cs_n, ras_n, cas_n, we_n} = 4'b1111;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		@(negedge ck);
		paddr  = addr;
		pwdata = data;
		pwrite = 1'b1;
		psel   = 1'b1;
		@(negedge ck);
		penable = 1'b1;
		@(negedge ck);
		{psel, penable, pwrite} = 3'b000;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
		// let the monitor pipeline drain first
		repeat (3) @(negedge ck);
		@(negedge ck);
		paddr  = addr;
		pwrite = 1'b0;
		psel   = 1'b1;
		@(negedge ck);
		penable = 1'b1;
		#(CLK_PERIOD / 4);
		data = prdata;
		// zero wait states, the access cycle always completes
		check_value("pready", 32'd1, {31'b0, pready});
		@(negedge ck);
		{psel, penable} = 2'b00;
	endtask

	// ----------------------------------------
	// vector handling
	// ----------------------------------------
	task automatic load_vectors();
		int    fd;
		string line;
		fd = $fopen(VEC_FILE, "r");
		if (fd == 0) begin
			abort_run("could not open the vector file");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				// skip comments and empty lines
				if (line.len() > 1 && line.getc(0) != "#") begin
					ops.push_back(line);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic run_op(input string line);
		string       kind;
		string       name;
		logic        cs, ras, cas, we;
		int          bank;
		int          n;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] got;
		void'($sscanf(line, "%s", kind));
		case (kind)
			"C": begin
				n = $sscanf(line, "%s %b %b %b %b %d %h", kind, cs, ras, cas, we, bank, addr);
				if (n != 7) abort_run({"bad command line in vectors: ", line});
				drive_cmd(cs, ras, cas, we, bank[BA_W-1:0], addr[ROW_W-1:0]);
			end
			"W": begin
				n = $sscanf(line, "%s %h %h", kind, addr, data);
				if (n != 3) abort_run({"bad write line in vectors: ", line});
				apb_write(addr[7:0], data);
			end
			"R": begin
				n = $sscanf(line, "%s %h %h %s", kind, addr, data, name);
				if (n != 4) abort_run({"bad read line in vectors: ", line});
				apb_read(addr[7:0], got);
				check_value(name, data, got);
				// irq is the OR of the status bits
				if (addr[7:0] == REG_STATUS) begin
					check_value({name, "_irq"}, {31'b0, |data[1:0]}, {31'b0, irq});
				end
			end
			default: abort_run({"unknown operation in vectors: ", line});
		endcase
	endtask

	initial begin
		longint limit;
		ck      = 1'b0;
		rst     = 1'b1;
		{cs_n, ras_n, cas_n, we_n} = 4'b1111;
		ba      = '0;
		a       = '0;
		paddr   = '0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		pwdata  = '0;
		load_vectors();
		limit = ops.size() * CYCLES_PER_OP * CLK_PERIOD + MARGIN;
		fork
			begin
				#(limit);
				$display("timeout: vectors not finished after %0d time units", limit);
				abort_run("watchdog expired");
			end
		join_none
		repeat (3) @(posedge ck);
		@(negedge ck);
		rst = 1'b0;
		foreach (ops[i]) begin
			run_op(ops[i]);
		end
		repeat (2) @(negedge ck);
		$display("No errors");
		$finish;
	end

endmodule

// ==== tests/ddr3_mon_vectors.txt ====
# C cs_n ras_n cas_n we_n ba a : one bus command, a in hex
# W addr data : APB write, R addr expected name : checked APB read, all hex
R 08 00000000 open_after_reset
R 04 00000000 status_after_reset
R 10 00000000 act_cnt_after_reset
R 18 00000000 rd_cnt_after_reset
R 28 00000000 zq_cnt_after_reset
C 0 0 1 1 2 0155
C 0 0 1 1 5 0ABC
R 08 00000024 open_two_banks
C 0 0 1 0 2 0000
R 08 00000020 open_after_pre
C 0 0 1 0 0 0400
R 08 00000000 open_after_pre_all
C 0 0 1 1 5 0ABC
C 0 1 0 0 5 003A
R 0C 06AAF03A last_write
C 0 1 0 1 5 0410
R 08 00000000 open_after_auto_pre
C 0 0 0 1 0 0000
C 0 0 0 0 0 0000
C 0 1 1 0 0 0400
R 10 00000003 act_cnt
R 14 00000002 pre_cnt
R 18 00000001 rd_cnt
R 1C 00000001 wr_cnt
R 20 00000001 ref_cnt
R 24 00000001 mrs_cnt
R 28 00000001 zq_cnt
W 00 00000003
R 10 00000000 act_cnt_after_clear
R 14 00000000 pre_cnt_after_clear
R 1C 00000000 wr_cnt_after_clear
R 28 00000000 zq_cnt_after_clear
R 00 00000001 ctrl_after_clear
C 0 0 1 1 2 0155
C 0 0 1 1 2 0155
R 04 00000001 status_act_open
W 04 00000001
R 04 00000000 status_act_open_cleared
C 0 1 0 1 3 0000
R 04 00000002 status_access_closed
W 04 00000002
R 04 00000000 status_access_closed_cleared
W 00 00000000
C 0 0 1 1 6 0011
C 0 1 0 1 4 0000
R 08 00000044 open_while_disabled
R 04 00000000 status_while_disabled
R 10 00000002 act_cnt_while_disabled
R 18 00000001 rd_cnt_while_disabled
